/* design/pkt_stream_pkg.sv */
// Stream data width, data word type and the packed beat struct shared by all streams.

package pkt_stream_pkg;

   // Width of tdata on every stream of the engine.
   localparam int DATA_W = 64;

   // One data word as it appears on tdata.
   typedef logic [DATA_W-1:0] word_t;

   // One stream beat: the data word and its end-of-packet flag.
   // The sidebands tstrb, tkeep, tid, tdest and tuser are not carried.
   typedef struct packed {
      word_t tdata;
      logic  tlast;
   } axis_beat_t;

endpackage

/* design/hdr_format_pkg.sv */
// Header word field positions, field widths, clamp limits and the clamp functions.

package hdr_format_pkg;

   // Header length in words, word 0 included, in bits 7..0 of word 0.
   localparam int HLEN_LSB = 0;
   localparam int HLEN_W   = 8;

   // Total packet length in words, in bits 23..8 of word 0.
   localparam int PLEN_LSB = 8;
   localparam int PLEN_W   = 16;

   // Word counts inside the engine are this wide.
   localparam int LEN_W = 16;

   typedef logic [LEN_W-1:0] len_t;

   // Smallest header length; word 0 is always a header word.
   localparam len_t HLEN_MIN = len_t'(1);

   // A header length of 0 counts as 1.
   function automatic len_t clamp_hlen(input logic [HLEN_W-1:0] raw);
      return (raw == '0) ? HLEN_MIN : len_t'(raw);
   endfunction

   // A total length below the header length counts as the header length,
   // so such a packet carries no payload.
   function automatic len_t clamp_plen(input len_t hlen, input logic [PLEN_W-1:0] raw);
      return (len_t'(raw) < hlen) ? hlen : len_t'(raw);
   endfunction

endpackage

/* design/axis_reg_slice.sv */
// Two-entry skid-buffer register slice with registered ready and a typed payload.

`timescale 1ns/1ps

module axis_reg_slice #(
   parameter type slice_t = logic
) (
   input  logic   aclk,
   input  logic   aresetn,

   input  logic   s_valid,
   output logic   s_ready,
   input  slice_t s_data,

   output logic   m_valid,
   input  logic   m_ready,
   output slice_t m_data
);

   logic   m_valid_r;
   logic   s_ready_r;
   slice_t m_data_r;
   slice_t skid_data;

   // The skid entry is occupied exactly when s_ready_r is low.
   always_ff @(posedge aclk)
   begin
      if (!aresetn)
      begin
         m_valid_r <= 1'b0;
         s_ready_r <= 1'b1;
      end
      else
      begin
         if (s_ready_r)
         begin
            if (m_valid_r && !m_ready)
            begin
               // Main entry is stalled, so an arriving beat parks in the skid entry.
               if (s_valid)
               begin
                  s_ready_r <= 1'b0;
               end
            end
            else
            begin
               m_valid_r <= s_valid;
            end
         end
         else if (m_ready)
         begin
            // Both entries full and the main one drains; the skid beat moves up.
            m_valid_r <= 1'b1;
            s_ready_r <= 1'b1;
         end
      end
   end

   always_ff @(posedge aclk)
   begin
      if (s_ready_r && (!m_valid_r || m_ready))
      begin
         m_data_r <= s_data;
      end
      else if (!s_ready_r && m_ready)
      begin
         m_data_r <= skid_data;
      end

      if (s_ready_r && m_valid_r && !m_ready)
      begin
         skid_data <= s_data;
      end
   end

   assign s_ready = s_ready_r;
   assign m_valid = m_valid_r;
   assign m_data  = m_data_r;

endmodule

/* design/header_removal_core.sv */
// Header removal core: per-packet FSM that parses word 0 and routes words to aux or payload.

`timescale 1ns/1ps

module header_removal_core #(
   parameter int data_w = pkt_stream_pkg::DATA_W
) (
   input  logic                       aclk,
   input  logic                       aresetn,

   input  logic                       ap_start,
   output logic                       ap_idle,
   output logic                       ap_done,

   input  pkt_stream_pkg::word_t      in_dout,
   input  logic                       in_empty_n,
   output logic                       in_read,

   output pkt_stream_pkg::axis_beat_t aux_din,
   input  logic                       aux_full_n,
   output logic                       aux_write,

   output pkt_stream_pkg::axis_beat_t pay_din,
   input  logic                       pay_full_n,
   output logic                       pay_write
);

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_WAIT_FIRST,
      ST_HEADER,
      ST_PAYLOAD
   } state_t;

   state_t                state;
   hdr_format_pkg::len_t  cnt;
   hdr_format_pkg::len_t  hlen_r;
   hdr_format_pkg::len_t  plen_r;
   hdr_format_pkg::len_t  hlen_w;
   hdr_format_pkg::len_t  plen_w;
   logic [data_w-1:0]     word0;
   logic                  hdr_last;
   logic                  pkt_last;
   logic                  aux_last;
   logic                  pay_last;

   // Length fields of the word at the input, only meaningful in ST_WAIT_FIRST.
   assign word0  = in_dout;
   assign hlen_w = hdr_format_pkg::clamp_hlen(
                      word0[hdr_format_pkg::HLEN_LSB +: hdr_format_pkg::HLEN_W]);
   assign plen_w = hdr_format_pkg::clamp_plen(
                      hlen_w, word0[hdr_format_pkg::PLEN_LSB +: hdr_format_pkg::PLEN_W]);

   // cnt is the index of the word at the input within the current packet.
   assign hdr_last = (cnt == hlen_r - hdr_format_pkg::len_t'(1));
   assign pkt_last = (cnt == plen_r - hdr_format_pkg::len_t'(1));

   assign ap_idle = (state == ST_IDLE);

   // Reads and writes happen in the same cycle, like a flow-through FIFO.
   always_comb
   begin
      in_read   = 1'b0;
      aux_write = 1'b0;
      pay_write = 1'b0;
      aux_last  = 1'b0;
      pay_last  = 1'b0;
      ap_done   = 1'b0;
      case (state)
         ST_WAIT_FIRST:
         begin
            in_read   = in_empty_n && aux_full_n;
            aux_write = in_read;
            aux_last  = (hlen_w == hdr_format_pkg::HLEN_MIN);
            ap_done   = in_read && (plen_w == hdr_format_pkg::HLEN_MIN);
         end
         ST_HEADER:
         begin
            in_read   = in_empty_n && aux_full_n;
            aux_write = in_read;
            aux_last  = hdr_last;
            // Inside the header, pkt_last can only hold together with hdr_last.
            ap_done   = in_read && pkt_last;
         end
         ST_PAYLOAD:
         begin
            in_read   = in_empty_n && pay_full_n;
            pay_write = in_read;
            pay_last  = pkt_last;
            ap_done   = in_read && pkt_last;
         end
         default:
         begin
            in_read = 1'b0;
         end
      endcase
   end

   assign aux_din = '{tdata: in_dout, tlast: aux_last};
   assign pay_din = '{tdata: in_dout, tlast: pay_last};

   always_ff @(posedge aclk)
   begin
      if (!aresetn)
      begin
         state <= ST_IDLE;
         cnt   <= '0;
      end
      else
      begin
         case (state)
            ST_IDLE:
            begin
               if (ap_start)
               begin
                  state <= ST_WAIT_FIRST;
               end
            end
            ST_WAIT_FIRST:
            begin
               if (in_read)
               begin
                  cnt <= hdr_format_pkg::len_t'(1);
                  if (plen_w == hdr_format_pkg::HLEN_MIN)
                  begin
                     state <= ST_IDLE;
                  end
                  else if (hlen_w == hdr_format_pkg::HLEN_MIN)
                  begin
                     state <= ST_PAYLOAD;
                  end
                  else
                  begin
                     state <= ST_HEADER;
                  end
               end
            end
            ST_HEADER:
            begin
               if (in_read)
               begin
                  cnt <= cnt + hdr_format_pkg::len_t'(1);
                  if (hdr_last)
                  begin
                     state <= pkt_last ? ST_IDLE : ST_PAYLOAD;
                  end
               end
            end
            ST_PAYLOAD:
            begin
               if (in_read)
               begin
                  cnt <= cnt + hdr_format_pkg::len_t'(1);
                  if (pkt_last)
                  begin
                     state <= ST_IDLE;
                  end
               end
            end
            default:
            begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // Clamped lengths are held for the rest of the packet.
   always_ff @(posedge aclk)
   begin
      if ((state == ST_WAIT_FIRST) && in_read)
      begin
         hlen_r <= hlen_w;
         plen_r <= plen_w;
      end
   end

endmodule

/* design/header_removal_axi.sv */
// AXI4-Stream top level: start-pulse control, core and register slices on all three streams.

`timescale 1ns/1ps

module header_removal_axi #(
   parameter int data_w = pkt_stream_pkg::DATA_W
) (
   input  logic                  aclk,
   input  logic                  aresetn,

   input  logic                  s_axis_tvalid,
   output logic                  s_axis_tready,
   input  pkt_stream_pkg::word_t s_axis_tdata,
   input  logic                  s_axis_tlast,

   output logic                  m_axis_aux_tvalid,
   input  logic                  m_axis_aux_tready,
   output pkt_stream_pkg::word_t m_axis_aux_tdata,
   output logic                  m_axis_aux_tlast,

   output logic                  m_axis_pay_tvalid,
   input  logic                  m_axis_pay_tready,
   output pkt_stream_pkg::word_t m_axis_pay_tdata,
   output logic                  m_axis_pay_tlast
);

   pkt_stream_pkg::axis_beat_t in_beat;
   pkt_stream_pkg::axis_beat_t in_beat_q;
   pkt_stream_pkg::axis_beat_t aux_din;
   pkt_stream_pkg::axis_beat_t pay_din;
   pkt_stream_pkg::axis_beat_t aux_beat;
   pkt_stream_pkg::axis_beat_t pay_beat;

   logic in_empty_n;
   logic in_read;
   logic aux_full_n;
   logic aux_write;
   logic pay_full_n;
   logic pay_write;

   logic start_r;
   logic start_cnt;
   logic ap_idle;
   logic ap_done;

   // Packet boundaries come from word 0, so the input tlast is not carried.
   assign in_beat = '{tdata: s_axis_tdata, tlast: 1'b0};

   // One start pulse after reset release, then one right after every ap_done.
   always_ff @(posedge aclk)
   begin
      if (!aresetn)
      begin
         start_r   <= 1'b0;
         start_cnt <= 1'b0;
      end
      else
      begin
         start_r <= 1'b0;
         if (!start_cnt || ap_done)
         begin
            start_r   <= 1'b1;
            start_cnt <= 1'b1;
         end
      end
   end

   axis_reg_slice #(
      .slice_t (pkt_stream_pkg::axis_beat_t)
   ) i_in_slice (
      .aclk    (aclk),
      .aresetn (aresetn),
      .s_valid (s_axis_tvalid),
      .s_ready (s_axis_tready),
      .s_data  (in_beat),
      .m_valid (in_empty_n),
      .m_ready (in_read),
      .m_data  (in_beat_q)
   );

   header_removal_core #(
      .data_w (data_w)
   ) i_core (
      .aclk       (aclk),
      .aresetn    (aresetn),
      .ap_start   (start_r && ap_idle),
      .ap_idle    (ap_idle),
      .ap_done    (ap_done),
      .in_dout    (in_beat_q.tdata),
      .in_empty_n (in_empty_n),
      .in_read    (in_read),
      .aux_din    (aux_din),
      .aux_full_n (aux_full_n),
      .aux_write  (aux_write),
      .pay_din    (pay_din),
      .pay_full_n (pay_full_n),
      .pay_write  (pay_write)
   );

   axis_reg_slice #(
      .slice_t (pkt_stream_pkg::axis_beat_t)
   ) i_aux_slice (
      .aclk    (aclk),
      .aresetn (aresetn),
      .s_valid (aux_write),
      .s_ready (aux_full_n),
      .s_data  (aux_din),
      .m_valid (m_axis_aux_tvalid),
      .m_ready (m_axis_aux_tready),
      .m_data  (aux_beat)
   );

   axis_reg_slice #(
      .slice_t (pkt_stream_pkg::axis_beat_t)
   ) i_pay_slice (
      .aclk    (aclk),
      .aresetn (aresetn),
      .s_valid (pay_write),
      .s_ready (pay_full_n),
      .s_data  (pay_din),
      .m_valid (m_axis_pay_tvalid),
      .m_ready (m_axis_pay_tready),
      .m_data  (pay_beat)
   );

   assign m_axis_aux_tdata = aux_beat.tdata;
   assign m_axis_aux_tlast = aux_beat.tlast;
   assign m_axis_pay_tdata = pay_beat.tdata;
   assign m_axis_pay_tlast = pay_beat.tlast;

endmodule

/* tb/header_removal_checker.sv */
// Bound assertions on the three AXI4-Stream handshakes and the output state after reset.

`timescale 1ns/1ps

module header_removal_checker (
   input logic                  aclk,
   input logic                  aresetn,
   input logic                  s_axis_tvalid,
   input logic                  s_axis_tready,
   input pkt_stream_pkg::word_t s_axis_tdata,
   input logic                  m_axis_aux_tvalid,
   input logic                  m_axis_aux_tready,
   input pkt_stream_pkg::word_t m_axis_aux_tdata,
   input logic                  m_axis_aux_tlast,
   input logic                  m_axis_pay_tvalid,
   input logic                  m_axis_pay_tready,
   input pkt_stream_pkg::word_t m_axis_pay_tdata,
   input logic                  m_axis_pay_tlast
);

   int failures = 0;

   // A stalled beat keeps valid high and its content unchanged until it is taken.
   s_held: assert property (@(posedge aclk) disable iff (!aresetn)
      s_axis_tvalid && !s_axis_tready |=> s_axis_tvalid && $stable(s_axis_tdata))
   else
   begin
      failures++;
      $error("s_axis beat changed or vanished while stalled");
   end

   aux_held: assert property (@(posedge aclk) disable iff (!aresetn)
      m_axis_aux_tvalid && !m_axis_aux_tready |=>
         m_axis_aux_tvalid && $stable({m_axis_aux_tdata, m_axis_aux_tlast}))
   else
   begin
      failures++;
      $error("m_axis_aux beat changed or vanished while stalled");
   end

   pay_held: assert property (@(posedge aclk) disable iff (!aresetn)
      m_axis_pay_tvalid && !m_axis_pay_tready |=>
         m_axis_pay_tvalid && $stable({m_axis_pay_tdata, m_axis_pay_tlast}))
   else
   begin
      failures++;
      $error("m_axis_pay beat changed or vanished while stalled");
   end

   out_reset: assert property (@(posedge aclk)
      $rose(aresetn) |-> !m_axis_aux_tvalid && !m_axis_pay_tvalid)
   else
   begin
      failures++;
      $error("Output valid high in the first cycle after reset");
   end

endmodule

bind header_removal_axi header_removal_checker i_checker (.*);

/* tb/hr_scoreboard.sv */
// Scoreboard: header split reference model, output stream comparison and per-test reporting.

`timescale 1ns/1ps

module hr_scoreboard (
   input  logic                       aclk,
   input  logic                       aresetn,
   input  logic                       s_valid,
   input  logic                       s_ready,
   input  pkt_stream_pkg::word_t      s_data,
   input  logic                       aux_valid,
   input  logic                       aux_ready,
   input  pkt_stream_pkg::axis_beat_t aux_beat,
   input  logic                       pay_valid,
   input  logic                       pay_ready,
   input  pkt_stream_pkg::axis_beat_t pay_beat,
   input  logic                       test_end,
   input  logic                       check_latency,
   input  logic                       expect_stall,
   output int                         pending,
   output int                         passed_tests,
   output int                         failed_tests
);

   pkt_stream_pkg::axis_beat_t exp_aux[$];
   pkt_stream_pkg::axis_beat_t exp_pay[$];
   int                         aux_stamp[$];
   hdr_format_pkg::len_t       word_idx = '0;
   hdr_format_pkg::len_t       hdr_words = '0;
   hdr_format_pkg::len_t       pkt_words = '0;
   int                         cycle = 0;
   int                         test_errs = 0;
   int                         test_num = 0;
   logic                       saw_stall = 1'b0;

   initial
   begin
      pending      = 0;
      passed_tests = 0;
      failed_tests = 0;
   end

   // Word 0 sets the split; a zero header length means one word and a short total
   // length is raised to the header length.
   task automatic predict(input pkt_stream_pkg::word_t w);
      pkt_stream_pkg::axis_beat_t beat;
      if (word_idx == '0)
      begin
         hdr_words = hdr_format_pkg::len_t'(w[hdr_format_pkg::HLEN_LSB +: hdr_format_pkg::HLEN_W]);
         pkt_words = w[hdr_format_pkg::PLEN_LSB +: hdr_format_pkg::PLEN_W];
         if (hdr_words == '0)
            hdr_words = hdr_format_pkg::len_t'(1);
         if (pkt_words < hdr_words)
            pkt_words = hdr_words;
      end
      beat.tdata = w;
      if (word_idx < hdr_words)
      begin
         beat.tlast = (word_idx == hdr_words - hdr_format_pkg::len_t'(1));
         exp_aux.push_back(beat);
         aux_stamp.push_back((word_idx == '0) ? cycle : -1);
      end
      else
      begin
         beat.tlast = (word_idx == pkt_words - hdr_format_pkg::len_t'(1));
         exp_pay.push_back(beat);
      end
      if (word_idx == pkt_words - hdr_format_pkg::len_t'(1))
         word_idx = '0;
      else
         word_idx = word_idx + hdr_format_pkg::len_t'(1);
   endtask

   task automatic compare_beat(input string stream, input pkt_stream_pkg::axis_beat_t exp,
                               input pkt_stream_pkg::axis_beat_t got);
      if (got.tdata !== exp.tdata)
      begin
         $display("ERROR %s_tdata expected 0x%h got 0x%h", stream, exp.tdata, got.tdata);
         test_errs++;
      end
      if (got.tlast !== exp.tlast)
      begin
         $display("ERROR %s_tlast expected 0x%h got 0x%h", stream, exp.tlast, got.tlast);
         test_errs++;
      end
   endtask

   task automatic check_aux();
      int stamp;
      if (exp_aux.size() == 0)
      begin
         $display("A beat came out on m_axis_aux while no aux word was expected");
         test_errs++;
      end
      else
      begin
         stamp = aux_stamp.pop_front();
         compare_beat("m_axis_aux", exp_aux.pop_front(), aux_beat);
         if (check_latency && stamp >= 0 && cycle - stamp != 2)
         begin
            $display("First aux word left %0d cycles after acceptance instead of 2",
                     cycle - stamp);
            test_errs++;
         end
      end
   endtask

   task automatic check_pay();
      if (exp_pay.size() == 0)
      begin
         $display("A beat came out on m_axis_pay while no payload word was expected");
         test_errs++;
      end
      else
         compare_beat("m_axis_pay", exp_pay.pop_front(), pay_beat);
   endtask

   task automatic close_test();
      if (exp_aux.size() != 0 || exp_pay.size() != 0)
      begin
         $display("Test %0d: %0d aux and %0d payload beats are missing", test_num,
                  exp_aux.size(), exp_pay.size());
         test_errs++;
         exp_aux.delete();
         aux_stamp.delete();
         exp_pay.delete();
      end
      if (expect_stall && !saw_stall)
      begin
         $display("Test %0d: s_axis_tready never dropped under back-pressure", test_num);
         test_errs++;
      end
      if (test_errs == 0)
      begin
         passed_tests++;
         $display("Test %0d passed", test_num);
      end
      else
      begin
         failed_tests++;
         $display("Test %0d failed with %0d errors", test_num, test_errs);
      end
      test_num++;
      test_errs = 0;
      saw_stall = 1'b0;
   endtask

   // Sampling on the falling edge sees every handshake of the next rising edge.
   always @(negedge aclk)
   begin
      if (aresetn)
      begin
         cycle++;
         if (!s_ready)
            saw_stall = 1'b1;
         if (s_valid && s_ready)
            predict(s_data);
         if (aux_valid && aux_ready)
            check_aux();
         if (pay_valid && pay_ready)
            check_pay();
         if (test_end)
            close_test();
         pending = exp_aux.size() + exp_pay.size();
      end
   end

endmodule

/* tb/tb_header_removal.sv */
// Testbench top: clock, reset, seeded random packets, back-pressure, timeout, DUT and summary.

`timescale 1ns/1ps

module tb_header_removal;

   localparam int NUM_TESTS = 6;
   // The six tests are a fixed packet, random packets, malformed headers,
   // an aux stall, a payload stall and both outputs stalled.
   localparam int GAP_PCT [NUM_TESTS]       = '{0, 25, 25, 25, 25, 25};
   localparam int AUX_STALL_PCT [NUM_TESTS] = '{0, 0, 0, 60, 0, 60};
   localparam int PAY_STALL_PCT [NUM_TESTS] = '{0, 0, 0, 0, 60, 60};

   logic                  aclk;
   logic                  aresetn;
   logic                  s_axis_tvalid;
   logic                  s_axis_tready;
   pkt_stream_pkg::word_t s_axis_tdata;
   logic                  s_axis_tlast;
   logic                  m_axis_aux_tvalid;
   logic                  m_axis_aux_tready;
   pkt_stream_pkg::word_t m_axis_aux_tdata;
   logic                  m_axis_aux_tlast;
   logic                  m_axis_pay_tvalid;
   logic                  m_axis_pay_tready;
   pkt_stream_pkg::word_t m_axis_pay_tdata;
   logic                  m_axis_pay_tlast;
   logic                  test_end;
   logic                  check_latency;
   logic                  expect_stall;
   int                    pending;
   int                    passed_tests;
   int                    failed_tests;

   pkt_stream_pkg::word_t stim[$];
   int                    test_start[NUM_TESTS+1];
   int                    aux_stall_pct = 0;
   int                    pay_stall_pct = 0;
   int                    cycle = 0;
   int                    limit = 0;

   header_removal_axi #(
      .data_w (pkt_stream_pkg::DATA_W)
   ) i_header_removal_axi (
      .aclk              (aclk),
      .aresetn           (aresetn),
      .s_axis_tvalid     (s_axis_tvalid),
      .s_axis_tready     (s_axis_tready),
      .s_axis_tdata      (s_axis_tdata),
      .s_axis_tlast      (s_axis_tlast),
      .m_axis_aux_tvalid (m_axis_aux_tvalid),
      .m_axis_aux_tready (m_axis_aux_tready),
      .m_axis_aux_tdata  (m_axis_aux_tdata),
      .m_axis_aux_tlast  (m_axis_aux_tlast),
      .m_axis_pay_tvalid (m_axis_pay_tvalid),
      .m_axis_pay_tready (m_axis_pay_tready),
      .m_axis_pay_tdata  (m_axis_pay_tdata),
      .m_axis_pay_tlast  (m_axis_pay_tlast)
   );

   hr_scoreboard i_scoreboard (
      .aclk          (aclk),
      .aresetn       (aresetn),
      .s_valid       (s_axis_tvalid),
      .s_ready       (s_axis_tready),
      .s_data        (s_axis_tdata),
      .aux_valid     (m_axis_aux_tvalid),
      .aux_ready     (m_axis_aux_tready),
      .aux_beat      ({m_axis_aux_tdata, m_axis_aux_tlast}),
      .pay_valid     (m_axis_pay_tvalid),
      .pay_ready     (m_axis_pay_tready),
      .pay_beat      ({m_axis_pay_tdata, m_axis_pay_tlast}),
      .test_end      (test_end),
      .check_latency (check_latency),
      .expect_stall  (expect_stall),
      .pending       (pending),
      .passed_tests  (passed_tests),
      .failed_tests  (failed_tests)
   );

   initial
   begin
      aclk = 1'b0;
      forever #4 aclk = ~aclk;
   end

   always @(posedge aclk)
   begin
      cycle++;
      if (limit > 0 && cycle >= limit)
      begin
         $display("Timeout: the run did not finish within %0d cycles", limit);
         $display("TEST FAIL");
         $finish;
      end
   end

   // The packet occupies the clamped total length in words.
   task automatic add_packet(input logic [7:0] hlen_raw, input logic [15:0] plen_raw);
      int                    hlen;
      int                    plen;
      pkt_stream_pkg::word_t w;
      hlen = (hlen_raw == 8'd0) ? 1 : int'(hlen_raw);
      plen = (int'(plen_raw) < hlen) ? hlen : int'(plen_raw);
      w = {$urandom, $urandom};
      w[hdr_format_pkg::HLEN_LSB +: hdr_format_pkg::HLEN_W] = hlen_raw;
      w[hdr_format_pkg::PLEN_LSB +: hdr_format_pkg::PLEN_W] = plen_raw;
      stim.push_back(w);
      for (int i = 1; i < plen; i++)
         stim.push_back({$urandom, $urandom});
   endtask

   task automatic add_random_packet();
      int h;
      h = $urandom_range(4, 1);
      add_packet(8'(h), 16'($urandom_range(12, h)));
   endtask

   task automatic build_tests();
      int h;
      test_start[0] = 0;
      add_packet(8'd3, 16'd10);
      test_start[1] = stim.size();
      repeat (30) add_random_packet();
      test_start[2] = stim.size();
      for (int i = 0; i < 12; i++)
      begin
         h = $urandom_range(4, 2);
         if (i % 2 == 0)
            add_packet(8'd0, 16'($urandom_range(12, 0)));
         else
            add_packet(8'(h), 16'($urandom_range(h - 1, 0)));
      end
      for (int t = 3; t < NUM_TESTS; t++)
      begin
         test_start[t] = stim.size();
         repeat (20) add_random_packet();
      end
      test_start[NUM_TESTS] = stim.size();
   endtask

   task automatic next_cycle();
      @(posedge aclk);
      #1;
      m_axis_aux_tready = (($urandom % 100) >= aux_stall_pct);
      m_axis_pay_tready = (($urandom % 100) >= pay_stall_pct);
   endtask

   // Input tready is registered, so its value now decides the coming edge.
   task automatic send_word(input pkt_stream_pkg::word_t w, input int gap_pct);
      logic accepted;
      while (($urandom % 100) < gap_pct)
         next_cycle();
      s_axis_tvalid = 1'b1;
      s_axis_tdata  = w;
      accepted      = 1'b0;
      while (!accepted)
      begin
         accepted = s_axis_tready;
         next_cycle();
      end
      s_axis_tvalid = 1'b0;
   endtask

   task automatic run_test(input int t);
      int idle;
      aux_stall_pct = AUX_STALL_PCT[t];
      pay_stall_pct = PAY_STALL_PCT[t];
      check_latency = (t == 0);
      expect_stall  = (AUX_STALL_PCT[t] != 0) || (PAY_STALL_PCT[t] != 0);
      for (int i = test_start[t]; i < test_start[t + 1]; i++)
         send_word(stim[i], GAP_PCT[t]);
      idle = 0;
      while (pending != 0 && idle < 500)
      begin
         next_cycle();
         idle++;
      end
      repeat (5) next_cycle();
      test_end = 1'b1;
      next_cycle();
      test_end = 1'b0;
   endtask

   initial
   begin
      void'($urandom(32'h4d24_b640));
      aresetn           = 1'b0;
      s_axis_tvalid     = 1'b0;
      s_axis_tdata      = '0;
      s_axis_tlast      = 1'b0;
      m_axis_aux_tready = 1'b1;
      m_axis_pay_tready = 1'b1;
      test_end          = 1'b0;
      check_latency     = 1'b0;
      expect_stall      = 1'b0;
      build_tests();
      limit = stim.size() * 8 + 200;
      repeat (2) @(posedge aclk);
      #1;
      aresetn = 1'b1;
      repeat (3) next_cycle();
      for (int t = 0; t < NUM_TESTS; t++)
         run_test(t);
      repeat (2) next_cycle();
      $display("Summary: %0d tests passed, %0d tests failed, %0d assertion failures",
               passed_tests, failed_tests, i_header_removal_axi.i_checker.failures);
      if (passed_tests == NUM_TESTS && failed_tests == 0 &&
          i_header_removal_axi.i_checker.failures == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

/* tb.f */
design/pkt_stream_pkg.sv
design/hdr_format_pkg.sv
design/axis_reg_slice.sv
design/header_removal_core.sv
design/header_removal_axi.sv
tb/header_removal_checker.sv
tb/hr_scoreboard.sv
tb/tb_header_removal.sv

/* Makefile */
TOP := tb_header_removal

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --top-module $(TOP) -f tb.f

obj_dir/V$(TOP): tb.f $(shell cat tb.f)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	@if grep -q "TEST FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" sim.log; then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
